//--- Bender.yml
package:
  name: fpga_core

sources:
  # RTL in compile order.
  - files:
      - hdl/pcie_lite_pkg.sv
      - hdl/cpl_if.sv
      - hdl/cq_request_handler.sv
      - hdl/cpl_fifo.sv
      - hdl/cc_completion_formatter.sv
      - hdl/fpga_core.sv
  # Testbench, top module tb_fpga_core.
  - target: simulation
    files:
      - verif/cc_checker.sv
      - verif/tb_fpga_core.sv

//--- hdl/cc_completion_formatter.sv
// Builds CC words from completion entries.
// The word is registered and held while cc_valid is high and cc_ready low.
// Data is forced to zero for UR completions.
`timescale 1ns/1ns

module cc_completion_formatter (
    input  logic                       clk,
    input  logic                       arst_n,
    cpl_if.dst                         cpl,
    output logic [pcie_lite_pkg::CC_W-1:0] cc_data,
    output logic                       cc_valid,
    input  logic                       cc_ready
);
    import pcie_lite_pkg::*;

    logic        take;
    logic [6:0]  lower_addr;
    logic [31:0] cpl_data;

    assign cpl.ready = !cc_valid || cc_ready;
    assign take      = cpl.valid && cpl.ready;

    assign lower_addr = {cpl.addr, 2'b00};  // Byte address of the dword.
    assign cpl_data   = (cpl.status == CPL_UR) ? 32'd0 : cpl.data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cc_valid <= 1'b0;
        end else if (take) begin
            cc_valid <= 1'b1;
        end else if (cc_ready) begin
            cc_valid <= 1'b0;
        end
    end

    // Word layout as in the package.
    always_ff @(posedge clk) begin
        if (take) begin
            cc_data <= {2'b00,
                        cpl.status,
                        cpl.tag,
                        lower_addr,
                        12'(CPL_BYTE_COUNT),
                        cpl_data};
        end
    end

endmodule

//--- hdl/cpl_fifo.sv
// Circular buffer of completion entries.
// DEPTH must be a power of two, at least 2.
// Push and pop can share a cycle, and ready is low while full.
`timescale 1ns/1ns

module cpl_fifo #(
    parameter int DEPTH = 4
) (
    input  logic clk,
    input  logic arst_n,
    cpl_if.dst   wr,
    cpl_if.src   rd
);
    import pcie_lite_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [TAG_W-1:0] tag_mem    [DEPTH];
    logic [4:0]       addr_mem   [DEPTH];
    logic [2:0]       status_mem [DEPTH];
    logic [31:0]      data_mem   [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign wr.ready = (count != CNT_W'(DEPTH));
    assign rd.valid = (count != '0);

    assign push = wr.valid && wr.ready;
    assign pop  = rd.valid && rd.ready;

    // Head entry, shown without a register stage.
    assign rd.tag    = tag_mem[rd_ptr];
    assign rd.addr   = addr_mem[rd_ptr];
    assign rd.status = status_mem[rd_ptr];
    assign rd.data   = data_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            tag_mem[wr_ptr]    <= wr.tag;
            addr_mem[wr_ptr]   <= wr.addr;
            status_mem[wr_ptr] <= wr.status;
            data_mem[wr_ptr]   <= wr.data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps at DEPTH.
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- hdl/cpl_if.sv
// Completion entry link with a valid/ready handshake.
// An entry moves on a rising edge with valid and ready both high.
// Valid holds with stable fields until the transfer.
`timescale 1ns/1ns

interface cpl_if;
    import pcie_lite_pkg::*;

    logic             valid;
    logic             ready;
    logic [TAG_W-1:0] tag;
    logic [4:0]       addr;    // Low bits of the dword address.
    logic [2:0]       status;
    logic [31:0]      data;

    modport src (
        output valid, tag, addr, status, data,
        input  ready
    );

    modport dst (
        input  valid, tag, addr, status, data,
        output ready
    );

endinterface

//--- hdl/cq_request_handler.sv
// Request decoder and BAR0 register block (16 x 32 bit, reset to zero).
// Writes are posted and take effect on the accepting edge.
// Reads and unsupported types leave one completion entry a cycle later.
// UR cases and dropped writes give a one-cycle error pulse after acceptance.
`timescale 1ns/1ns

module cq_request_handler (
    input  logic                    clk,
    input  logic                    arst_n,
    input  pcie_lite_pkg::cq_word_t cq_data,
    input  logic                    cq_valid,
    output logic                    cq_ready,
    cpl_if.src                      cpl,
    output logic                    error_uncor
);
    import pcie_lite_pkg::*;

    logic [31:0]      regs [2**REG_ADDR_W];
    logic             out_valid;
    logic [TAG_W-1:0] out_tag;
    logic [4:0]       out_addr;
    logic [2:0]       out_status;
    logic [31:0]      out_data;

    logic accept;
    logic is_read;
    logic is_write;
    logic rd_in_range;
    logic wr_in_range;
    logic need_cpl;
    logic req_error;

    // One-entry output register, so ready follows its state.
    assign cq_ready = !out_valid || cpl.ready;
    assign accept   = cq_valid && cq_ready;

    assign is_read     = (cq_data.rd.req_type == REQ_MEM_READ);
    assign is_write    = (cq_data.wr.req_type == REQ_MEM_WRITE);
    assign rd_in_range = (cq_data.rd.addr[ADDR_W-1:REG_ADDR_W] == '0);
    assign wr_in_range = (cq_data.wr.addr[ADDR_W-1:REG_ADDR_W] == '0);

    assign need_cpl  = !is_write;  // Reads and unsupported types complete.
    assign req_error = is_write ? !wr_in_range : !(is_read && rd_in_range);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (accept && is_write && wr_in_range) begin
            regs[cq_data.wr.addr[REG_ADDR_W-1:0]] <= cq_data.wr.data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid   <= 1'b0;
            error_uncor <= 1'b0;
        end else begin
            error_uncor <= accept && req_error;
            if (accept && need_cpl) begin
                out_valid <= 1'b1;
            end else if (cpl.ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // Completion payload.
    always_ff @(posedge clk) begin
        if (accept && need_cpl) begin
            out_tag  <= cq_data.rd.tag;
            out_addr <= cq_data.rd.addr[4:0];
            if (is_read && rd_in_range) begin
                out_status <= CPL_SC;
                out_data   <= regs[cq_data.rd.addr[REG_ADDR_W-1:0]];
            end else begin
                out_status <= CPL_UR;  // Out of range or unsupported type.
                out_data   <= '0;
            end
        end
    end

    assign cpl.valid  = out_valid;
    assign cpl.tag    = out_tag;
    assign cpl.addr   = out_addr;
    assign cpl.status = out_status;
    assign cpl.data   = out_data;

endmodule

//--- hdl/fpga_core.sv
// Core of the example completer.
// Single-word requests on CQ, completions on CC, both valid/ready.
// BAR0 holds 16 registers and completions leave in request order.
// status_error_uncor pulses once per UR case or dropped write.
`timescale 1ns/1ns

module fpga_core (
    input  logic                           clk,
    input  logic                           arst_n,

    input  logic [pcie_lite_pkg::CQ_W-1:0] cq_data,
    input  logic                           cq_valid,
    output logic                           cq_ready,

    output logic [pcie_lite_pkg::CC_W-1:0] cc_data,
    output logic                           cc_valid,
    input  logic                           cc_ready,

    output logic                           status_error_uncor
);
    import pcie_lite_pkg::*;

    cq_word_t cq_word;

    cpl_if req_cpl ();  // Handler to FIFO.
    cpl_if buf_cpl ();  // FIFO to formatter.

    assign cq_word = cq_data;

    cq_request_handler u_handler (
        .clk        (clk),
        .arst_n     (arst_n),
        .cq_data    (cq_word),
        .cq_valid   (cq_valid),
        .cq_ready   (cq_ready),
        .cpl        (req_cpl.src),
        .error_uncor(status_error_uncor)
    );

    cpl_fifo #(
        .DEPTH(4)
    ) u_cpl_fifo (
        .clk   (clk),
        .arst_n(arst_n),
        .wr    (req_cpl.dst),
        .rd    (buf_cpl.src)
    );

    cc_completion_formatter u_formatter (
        .clk     (clk),
        .arst_n  (arst_n),
        .cpl     (buf_cpl.dst),
        .cc_data (cc_data),
        .cc_valid(cc_valid),
        .cc_ready(cc_ready)
    );

endmodule

//--- hdl/pcie_lite_pkg.sv
// Shared widths, codes and the request word layout for the completer.
// Requests and completions are single 64-bit words with no multi-beat TLPs.
// BAR0 implements 16 dword registers and everything above them is out of range.
package pcie_lite_pkg;

    localparam int CQ_W       = 64;  // Request word width.
    localparam int CC_W       = 64;  // Completion word width.
    localparam int TAG_W      = 8;
    localparam int ADDR_W     = 16;  // Dword address field.
    localparam int REG_ADDR_W = 4;   // Implemented BAR0 aperture, in dword bits.

    // Request type codes. Codes 10 and 11 are unsupported.
    localparam logic [1:0] REQ_MEM_READ  = 2'b00;
    localparam logic [1:0] REQ_MEM_WRITE = 2'b01;

    // Completion status codes.
    localparam logic [2:0] CPL_SC = 3'b000;
    localparam logic [2:0] CPL_UR = 3'b001;

    localparam int CPL_BYTE_COUNT = 4;  // Every completion carries one dword.

    // Request word, read view. Low dword is reserved.
    typedef struct packed {
        logic [1:0]        req_type;  // [63:62]
        logic [TAG_W-1:0]  tag;       // [61:54]
        logic [5:0]        rsvd_hi;   // [53:48]
        logic [ADDR_W-1:0] addr;      // [47:32]
        logic [31:0]       rsvd_lo;   // [31:0]
    } cq_rd_t;

    // Request word, write view. Low dword carries the write data.
    typedef struct packed {
        logic [1:0]        req_type;
        logic [TAG_W-1:0]  tag;
        logic [5:0]        rsvd_hi;
        logic [ADDR_W-1:0] addr;
        logic [31:0]       data;
    } cq_wr_t;

    typedef union packed {
        cq_rd_t rd;
        cq_wr_t wr;
    } cq_word_t;

    // CC word layout:
    // [63:62] zero, [61:59] status, [58:51] tag, [50:44] lower address,
    // [43:32] byte count, [31:0] data (zero for UR).

endpackage

//--- sim.f
hdl/pcie_lite_pkg.sv
hdl/cpl_if.sv
hdl/cq_request_handler.sv
hdl/cpl_fifo.sv
hdl/cc_completion_formatter.sv
hdl/fpga_core.sv
verif/cc_checker.sv
verif/tb_fpga_core.sv

//--- verif/cc_checker.sv
// Scoreboard for the CC stream and the uncorrectable-error pulse.
// Expected words are queued by the testbench in request order.
// Samples DUT ports on the rising edge, before they update.
`timescale 1ns/1ns

module cc_checker (
    input logic        clk,
    input logic        arst_n,
    input logic [63:0] cc_data,
    input logic        cc_valid,
    input logic        cc_ready,
    input logic        cq_valid,
    input logic        cq_ready,
    input logic        status_error_uncor
);
    logic [63:0] exp_q [$];
    logic [63:0] exp_word;
    logic [63:0] held_data;
    logic        stalled = 1'b0;
    int          value_errs = 0;   // Wrong words, hold violations, bad idle state.
    int          unexp_cpls = 0;
    int          pulses_seen = 0;
    int          pulses_exp = 0;
    int          requests = 0;

    task automatic expect_cpl(input logic [63:0] word);
        exp_q.push_back(word);
    endtask

    task automatic expect_error();
        pulses_exp++;
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    task automatic check_idle();
        if (cc_valid !== 1'b0 || status_error_uncor !== 1'b0 || cq_ready !== 1'b1) begin
            $display("Fail at %0t ns: idle state wrong, cc_valid=%b error=%b cq_ready=%b",
                     $time, cc_valid, status_error_uncor, cq_ready);
            value_errs++;
        end
    endtask

    always @(posedge clk) begin
        if (!arst_n) begin
            stalled = 1'b0;
        end else begin
            if (cq_valid && cq_ready) requests++;
            if (status_error_uncor) pulses_seen++;
            // Word must hold while stalled.
            if (stalled && (cc_valid !== 1'b1 || cc_data !== held_data)) begin
                $display("Fail at %0t ns: CC word changed under back-pressure, held %h, now %h",
                         $time, held_data, cc_data);
                value_errs++;
            end
            if (cc_valid && cc_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Completion %h arrived at %0t ns when none was expected",
                             cc_data, $time);
                    unexp_cpls++;
                end else begin
                    exp_word = exp_q.pop_front();
                    if (cc_data !== exp_word) begin
                        $display("Fail at %0t ns: expected CC word %h, got %h",
                                 $time, exp_word, cc_data);
                        value_errs++;
                    end
                end
            end
            stalled   = cc_valid && !cc_ready;
            held_data = cc_data;
        end
    end

endmodule

//--- verif/tb_fpga_core.sv
// Testbench for fpga_core, driven from a table of requests and expected results.
// Inputs change 5 ns after the rising edge.
// cc_ready is random (seed 37) for back-pressure entries and high otherwise.
`timescale 1ns/1ns

module tb_fpga_core;
    import pcie_lite_pkg::*;

    localparam int WAIT_LIMIT = 200;  // Cycles allowed per wait loop.

    typedef struct packed {
        logic [1:0]  req_type;
        logic [7:0]  tag;
        logic [15:0] addr;
        logic [31:0] data;
        bit          cpl;       // Completion expected.
        logic [2:0]  status;
        logic [31:0] exp_data;
        bit          err;       // Error pulse expected.
        bit          bp;        // Random cc_ready while this entry is sent.
    } stim_t;

    logic        clk = 1'b0;
    logic        arst_n;
    logic [63:0] cq_data;
    logic        cq_valid;
    logic        cq_ready;
    logic [63:0] cc_data;
    logic        cc_valid;
    logic        cc_ready;
    logic        status_error_uncor;

    stim_t  stim_q [$];
    integer seed = 37;
    integer rnd;
    bit     bp_phase = 1'b0;
    bit     use_rnd;
    bit     timed_out = 1'b0;
    int     fails;

    fpga_core dut0 (
        .clk               (clk),
        .arst_n            (arst_n),
        .cq_data           (cq_data),
        .cq_valid          (cq_valid),
        .cq_ready          (cq_ready),
        .cc_data           (cc_data),
        .cc_valid          (cc_valid),
        .cc_ready          (cc_ready),
        .status_error_uncor(status_error_uncor)
    );

    cc_checker chk0 (
        .clk               (clk),
        .arst_n            (arst_n),
        .cc_data           (cc_data),
        .cc_valid          (cc_valid),
        .cc_ready          (cc_ready),
        .cq_valid          (cq_valid),
        .cq_ready          (cq_ready),
        .status_error_uncor(status_error_uncor)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        use_rnd = bp_phase;  // Taken at the edge, so it is stable.
        #5;
        if (use_rnd) begin
            rnd      = $random(seed);
            cc_ready = rnd[0];
        end else begin
            cc_ready = 1'b1;
        end
    end

    // Register contents written in the write phase.
    function automatic logic [31:0] fill(input logic [15:0] a);
        return {a, ~a};
    endfunction

    function automatic logic [63:0] cc_word(input logic [2:0] st, input logic [7:0] tag,
                                            input logic [15:0] a, input logic [31:0] d);
        logic [6:0] lower;
        lower = 7'(a * 4);  // Byte address, 7 bits.
        return {2'b00, st, tag, lower, 12'd4, d};  // One dword per completion.
    endfunction

    task automatic add_req(input logic [1:0] t, input logic [7:0] tag, input logic [15:0] a,
                           input logic [31:0] d, input bit cpl, input logic [2:0] st,
                           input logic [31:0] ed, input bit err, input bit bp);
        stim_q.push_back({t, tag, a, d, cpl, st, ed, err, bp});
    endtask

    task automatic build_table();
        // Registers read as zero after reset.
        add_req(REQ_MEM_READ, 8'h01, 16'd0, 32'd0, 1, CPL_SC, 32'd0, 0, 0);
        add_req(REQ_MEM_READ, 8'h02, 16'd7, 32'd0, 1, CPL_SC, 32'd0, 0, 0);
        add_req(REQ_MEM_READ, 8'h03, 16'd15, 32'd0, 1, CPL_SC, 32'd0, 0, 0);
        for (int r = 0; r < 16; r++) begin
            add_req(REQ_MEM_WRITE, 8'(8'h10 + r), 16'(r), fill(16'(r)), 0, CPL_SC, 32'd0, 0, 0);
        end
        add_req(REQ_MEM_READ, 8'h20, 16'd3, 32'd0, 1, CPL_SC, fill(16'd3), 0, 0);
        add_req(REQ_MEM_READ, 8'h21, 16'd9, 32'd0, 1, CPL_SC, fill(16'd9), 0, 0);
        add_req(REQ_MEM_READ, 8'h22, 16'd12, 32'd0, 1, CPL_SC, fill(16'd12), 0, 0);
        // Outside the aperture.
        add_req(REQ_MEM_READ, 8'h30, 16'd16, 32'd0, 1, CPL_UR, 32'd0, 1, 0);
        add_req(REQ_MEM_READ, 8'h31, 16'h0123, 32'hFFFF_FFFF, 1, CPL_UR, 32'd0, 1, 0);
        add_req(REQ_MEM_WRITE, 8'h32, 16'h0020, 32'hDEAD_BEEF, 0, CPL_SC, 32'd0, 1, 0);
        add_req(REQ_MEM_READ, 8'h33, 16'd0, 32'd0, 1, CPL_SC, fill(16'd0), 0, 0);
        // Unsupported type codes.
        add_req(2'b10, 8'h40, 16'd5, 32'h1234_5678, 1, CPL_UR, 32'd0, 1, 0);
        add_req(2'b11, 8'h41, 16'd6, 32'h8765_4321, 1, CPL_UR, 32'd0, 1, 0);
        for (int k = 0; k < 20; k++) begin
            add_req(REQ_MEM_READ, 8'(8'h80 + k), 16'((k * 5) % 16), 32'd0, 1, CPL_SC,
                    fill(16'((k * 5) % 16)), 0, 1);
        end
    endtask

    task automatic send_request(input stim_t s);
        int waited;
        waited   = 0;
        bp_phase = s.bp;
        cq_data  = {s.req_type, s.tag, 6'b0, s.addr, s.data};
        cq_valid = 1'b1;
        @(negedge clk);
        while (!cq_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!cq_ready) begin
            $display("Timeout at %0t ns: cq_ready stayed low for request tag %h", $time, s.tag);
            timed_out = 1'b1;
        end else begin
            @(posedge clk);  // Accepting edge.
            if (s.cpl) chk0.expect_cpl(cc_word(s.status, s.tag, s.addr, s.exp_data));
            if (s.err) chk0.expect_error();
            #5;
        end
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (chk0.pending() != 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (chk0.pending() != 0) begin
            $display("Timeout: %0d expected completions never arrived", chk0.pending());
        end
    endtask

    initial begin
        arst_n   = 1'b0;
        cq_data  = '0;
        cq_valid = 1'b0;
        cc_ready = 1'b1;
        build_table();
        repeat (4) @(posedge clk);
        #5;
        arst_n = 1'b1;
        @(negedge clk);
        chk0.check_idle();
        @(posedge clk);
        #5;
        foreach (stim_q[i]) begin
            if (!timed_out) send_request(stim_q[i]);
        end
        cq_valid = 1'b0;
        bp_phase = 1'b0;
        wait_for_drain();
        repeat (2) @(posedge clk);  // Let the last error pulse be seen.
        fails = chk0.value_errs + chk0.unexp_cpls + chk0.pending();
        $display("Requests %0d, wrong values %0d, unexpected %0d, missing %0d, pulses %0d of %0d",
                 chk0.requests, chk0.value_errs, chk0.unexp_cpls, chk0.pending(),
                 chk0.pulses_seen, chk0.pulses_exp);
        if (fails == 0 && chk0.pulses_seen == chk0.pulses_exp && !timed_out) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
